/* Makefile */
# Verilator build and run for the vector functional unit

VERILATOR  := verilator
TOP        := tb_vfu
RTL_TOP    := vfu_top
FILELIST   := project.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := Result: PASSED
SOURCES    := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* project.f */
+incdir+rtl
rtl/vfu_pkg.sv
rtl/vfu_ipu.sv
rtl/vfu_vrf.sv
rtl/vfu_sequencer.sv
rtl/vfu_writeback.sv
rtl/vfu_top.sv
test/tb_vfu.sv

/* rtl/vfu_ipu.sv */
// Integer processing unit, one SIMD lane
// Splits a 32-bit word into 8, 16 or 32-bit elements and applies the
// operation to each, wrapping modulo the element width
`include "vfu_settings.svh"

module vfu_ipu (
  input  vfu_pkg::vfu_op_e      op_i,
  input  vfu_pkg::vfu_sew_e     sew_i,
  input  logic [`VFU_ELEN-1:0]  op_s1_i,
  input  logic [`VFU_ELEN-1:0]  op_s2_i,
  input  logic [`VFU_ELEN-1:0]  op_d_i,
  output logic [`VFU_ELEN-1:0]  result_o
);

  vfu_pkg::lane_word_u s1;
  vfu_pkg::lane_word_u s2;
  vfu_pkg::lane_word_u d;
  vfu_pkg::lane_word_u res;

  assign s1.w = op_s1_i;
  assign s2.w = op_s2_i;
  assign d.w  = op_d_i;

  // Operands arrive sign extended, so signed compare works at any width
  function automatic logic [31:0] elem_op(
    input vfu_pkg::vfu_op_e    op,
    input logic signed [31:0]  a,
    input logic signed [31:0]  b,
    input logic signed [31:0]  acc
  );
    logic [31:0] r;
    case (op)
      vfu_pkg::OP_ADD:  r = b + a;
      vfu_pkg::OP_SUB:  r = b - a;
      vfu_pkg::OP_AND:  r = b & a;
      vfu_pkg::OP_OR:   r = b | a;
      vfu_pkg::OP_XOR:  r = b ^ a;
      vfu_pkg::OP_MIN:  r = (b < a) ? b : a;
      vfu_pkg::OP_MAX:  r = (b > a) ? b : a;
      // Low half of the product only
      vfu_pkg::OP_MACC: r = acc + a * b;
      default:          r = '0;
    endcase
    return r;
  endfunction

  always_comb begin : proc_elems
    res.w = '0;
    case (sew_i)
      vfu_pkg::SEW_8: begin
        for (int i = 0; i < 4; i++) begin
          res.b[i] = 8'(elem_op(op_i,
                                32'(signed'(s1.b[i])),
                                32'(signed'(s2.b[i])),
                                32'(signed'(d.b[i]))));
        end
      end
      vfu_pkg::SEW_16: begin
        for (int i = 0; i < 2; i++) begin
          res.h[i] = 16'(elem_op(op_i,
                                 32'(signed'(s1.h[i])),
                                 32'(signed'(s2.h[i])),
                                 32'(signed'(d.h[i]))));
        end
      end
      default: begin
        res.w = elem_op(op_i, s1.w, s2.w, d.w);
      end
    endcase
  end

  assign result_o = res.w;

endmodule

/* rtl/vfu_pkg.sv */
// Vector functional unit types
// Instruction format, lane word views and register file port bundles
`include "vfu_settings.svh"

package vfu_pkg;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_MIN  = 3'd5,
    OP_MAX  = 3'd6,
    OP_MACC = 3'd7
  } vfu_op_e;

  typedef enum logic [1:0] {
    SEW_8  = 2'd0,
    SEW_16 = 2'd1,
    SEW_32 = 2'd2
  } vfu_sew_e;

  // Register index in the upper bits, word within the register below
  typedef logic [`VFU_VADDR_W-1:0] vreg_addr_t;
  typedef logic [`VFU_VL_W-1:0]    vl_t;

  typedef struct packed {
    vfu_op_e                 op;
    vfu_sew_e                sew;
    vl_t                     vl;
    logic [`VFU_VREG_W-1:0]  vd;
    logic [`VFU_VREG_W-1:0]  vs1;
    logic [`VFU_VREG_W-1:0]  vs2;
    logic                    use_scalar;
    logic [`VFU_ELEN-1:0]    rs1;
  } vfu_req_t;

  // One lane word, read at whichever element width is active
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
    logic [31:0]      w;
  } lane_word_u;

  typedef struct packed {
    vreg_addr_t addr;
    logic       en;
  } vrf_rd_t;

  typedef struct packed {
    vreg_addr_t              addr;
    logic [`VFU_WORD_W-1:0]  data;
    logic [`VFU_WORD_B-1:0]  be;
    logic                    en;
  } vrf_wr_t;

endpackage

/* rtl/vfu_sequencer.sv */
// Vector instruction sequencer
// Holds one instruction, steps its register addresses group by group and
// alternates a read phase with a write phase until all elements are done
`include "vfu_settings.svh"

module vfu_sequencer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Request port
  input  vfu_pkg::vfu_req_t               req_i,
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  // VRF read side
  output vfu_pkg::vrf_rd_t [2:0]          rd_o,
  input  logic [2:0]                      rvalid_i,
  input  logic [2:0][`VFU_WORD_W-1:0]     rdata_i,
  // Operands to the lanes
  output logic [`VFU_WORD_W-1:0]          op1_o,
  output logic [`VFU_WORD_W-1:0]          op2_o,
  output logic [`VFU_WORD_W-1:0]          op3_o,
  output vfu_pkg::vfu_op_e                op_o,
  output vfu_pkg::vfu_sew_e               sew_o,
  // Writeback control
  output vfu_pkg::vreg_addr_t             wr_addr_o,
  output vfu_pkg::vl_t                    vl_left_o,
  output logic                            grp_valid_o,
  output logic                            busy_o
);

  vfu_pkg::vfu_req_t          req_q;
  vfu_pkg::vl_t               vl_left_q;
  vfu_pkg::vreg_addr_t [2:0]  addr_q;
  logic                       busy_q;
  logic                       wr_phase_q;

  logic                       accept;
  logic                       last_grp;
  logic [2:0]                 need;
  vfu_pkg::vl_t               elems_per_grp;

  assign accept      = req_valid_i && !busy_q;
  assign req_ready_o = !busy_q;
  assign busy_o      = busy_q;

  // 16, 8 or 4 elements fit in one VRF word
  assign elems_per_grp = vfu_pkg::vl_t'(`VFU_WORD_B >> req_q.sew);
  assign last_grp      = (vl_left_q <= elems_per_grp);

  // Port order: vs2, vs1, vd
  assign need = {req_q.op == vfu_pkg::OP_MACC, !req_q.use_scalar, 1'b1};

  //////////////////////////////////////////////////
  // Instruction state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
    if (!rst_ni) begin
      req_q      <= '0;
      vl_left_q  <= '0;
      addr_q     <= '0;
      busy_q     <= 1'b0;
      wr_phase_q <= 1'b0;
    end else if (accept) begin
      // A zero-length instruction is taken but never starts
      req_q      <= req_i;
      vl_left_q  <= req_i.vl;
      busy_q     <= (req_i.vl != '0);
      wr_phase_q <= 1'b0;
      addr_q[0]  <= {req_i.vs2, {`VFU_WIDX_W{1'b0}}};
      addr_q[1]  <= {req_i.vs1, {`VFU_WIDX_W{1'b0}}};
      addr_q[2]  <= {req_i.vd, {`VFU_WIDX_W{1'b0}}};
    end else if (busy_q) begin
      if (!wr_phase_q) begin
        wr_phase_q <= 1'b1;
      end else if (grp_valid_o) begin
        wr_phase_q <= 1'b0;
        for (int p = 0; p < 3; p++) begin
          addr_q[p] <= addr_q[p] + vfu_pkg::vreg_addr_t'(1);
        end
        if (last_grp) begin
          busy_q    <= 1'b0;
          vl_left_q <= '0;
        end else begin
          vl_left_q <= vl_left_q - elems_per_grp;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Operand requests and distribution
  //////////////////////////////////////////////////

  always_comb begin : proc_rd
    for (int p = 0; p < 3; p++) begin
      rd_o[p].addr = addr_q[p];
      rd_o[p].en   = busy_q && !wr_phase_q && need[p];
    end
  end

  assign grp_valid_o = busy_q && wr_phase_q && (&(rvalid_i | ~need));

  // Scalar broadcast at the element width
  always_comb begin : proc_op1
    if (!req_q.use_scalar) begin
      op1_o = rdata_i[1];
    end else begin
      case (req_q.sew)
        vfu_pkg::SEW_8:  op1_o = {(`VFU_WORD_B){req_q.rs1[7:0]}};
        vfu_pkg::SEW_16: op1_o = {(`VFU_WORD_B/2){req_q.rs1[15:0]}};
        default:         op1_o = {(`VFU_N_IPU){req_q.rs1}};
      endcase
    end
  end

  assign op2_o     = rdata_i[0];
  assign op3_o     = rdata_i[2];
  assign op_o      = req_q.op;
  assign sew_o     = req_q.sew;
  assign wr_addr_o = addr_q[2];
  assign vl_left_o = vl_left_q;

  // An idle cycle issues no read, so no data comes back after it
  a_no_read_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !busy_q |=> (rvalid_i == '0)
  ) else $error("VRF read data returned for an idle cycle");

endmodule

/* rtl/vfu_settings.svh */
// Vector functional unit build settings
// Lane count, lane width and register file geometry, plus derived widths
`ifndef VFU_SETTINGS_SVH
`define VFU_SETTINGS_SVH

`define VFU_N_IPU   4
`define VFU_ELEN    32
`define VFU_NR_VREG 32
`define VFU_VLEN    256

// Derived geometry of one VRF word (all lanes side by side)
`define VFU_WORD_W   (`VFU_N_IPU * `VFU_ELEN)
`define VFU_WORD_B   (`VFU_WORD_W / 8)
`define VFU_NR_WORDS (`VFU_NR_VREG * `VFU_VLEN / `VFU_WORD_W)
`define VFU_VREG_W   $clog2(`VFU_NR_VREG)
`define VFU_WIDX_W   $clog2(`VFU_VLEN / `VFU_WORD_W)
`define VFU_VADDR_W  (`VFU_VREG_W + `VFU_WIDX_W)
`define VFU_LANE_W   $clog2(`VFU_N_IPU)
`define VFU_WB_AW    (`VFU_VADDR_W + `VFU_LANE_W)
`define VFU_VL_W     ($clog2(`VFU_VLEN / 8) + 1)

`endif

/* rtl/vfu_top.sv */
// Vector functional unit top level
// Sequencer, a row of integer lanes, writeback and the register file
`include "vfu_settings.svh"

module vfu_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Instruction request
  input  vfu_pkg::vfu_req_t         req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  // Wishbone host port
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [`VFU_WB_AW-1:0]     wb_adr_i,
  input  logic [`VFU_ELEN-1:0]      wb_dat_i,
  input  logic [`VFU_ELEN/8-1:0]    wb_sel_i,
  output logic [`VFU_ELEN-1:0]      wb_dat_o,
  output logic                      wb_ack_o
);

  vfu_pkg::vrf_rd_t [2:0]           rd;
  logic [2:0]                       rvalid;
  logic [2:0][`VFU_WORD_W-1:0]      rdata;
  vfu_pkg::vrf_wr_t                 wr;

  logic [`VFU_WORD_W-1:0]           op1;
  logic [`VFU_WORD_W-1:0]           op2;
  logic [`VFU_WORD_W-1:0]           op3;
  logic [`VFU_WORD_W-1:0]           result;
  vfu_pkg::vfu_op_e                 op;
  vfu_pkg::vfu_sew_e                sew;
  vfu_pkg::vreg_addr_t              wr_addr;
  vfu_pkg::vl_t                     vl_left;
  logic                             grp_valid;
  logic                             busy;

  vfu_sequencer i_sequencer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rd_o        (rd),
    .rvalid_i    (rvalid),
    .rdata_i     (rdata),
    .op1_o       (op1),
    .op2_o       (op2),
    .op3_o       (op3),
    .op_o        (op),
    .sew_o       (sew),
    .wr_addr_o   (wr_addr),
    .vl_left_o   (vl_left),
    .grp_valid_o (grp_valid),
    .busy_o      (busy)
  );

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `VFU_N_IPU; i++) begin : gen_ipus
    vfu_ipu i_ipu (
      .op_i     (op),
      .sew_i    (sew),
      .op_s1_i  (op1[i*`VFU_ELEN +: `VFU_ELEN]),
      .op_s2_i  (op2[i*`VFU_ELEN +: `VFU_ELEN]),
      .op_d_i   (op3[i*`VFU_ELEN +: `VFU_ELEN]),
      .result_o (result[i*`VFU_ELEN +: `VFU_ELEN])
    );
  end

  vfu_writeback i_writeback (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .grp_valid_i (grp_valid),
    .wr_addr_i   (wr_addr),
    .vl_left_i   (vl_left),
    .sew_i       (sew),
    .result_i    (result),
    .wr_o        (wr)
  );

  vfu_vrf i_vrf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rd_i     (rd),
    .rdata_o  (rdata),
    .rvalid_o (rvalid),
    .wr_i     (wr),
    .busy_i   (busy),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

endmodule

/* rtl/vfu_vrf.sv */
// Vector register file
// Three registered read ports, one byte-enabled write port and a
// Wishbone classic host port that is served only while the unit is idle
`include "vfu_settings.svh"

module vfu_vrf (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Datapath ports
  input  vfu_pkg::vrf_rd_t [2:0]               rd_i,
  output logic [2:0][`VFU_WORD_W-1:0]          rdata_o,
  output logic [2:0]                           rvalid_o,
  input  vfu_pkg::vrf_wr_t                     wr_i,
  input  logic                                 busy_i,
  // Host port
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  input  logic                                 wb_we_i,
  input  logic [`VFU_WB_AW-1:0]                wb_adr_i,
  input  logic [`VFU_ELEN-1:0]                 wb_dat_i,
  input  logic [`VFU_ELEN/8-1:0]               wb_sel_i,
  output logic [`VFU_ELEN-1:0]                 wb_dat_o,
  output logic                                 wb_ack_o
);

  localparam int unsigned LaneB = `VFU_ELEN / 8;

  // Storage, one entry per VRF word, split as lane then byte
  logic [`VFU_N_IPU-1:0][LaneB-1:0][7:0] mem_q [`VFU_NR_WORDS];

  vfu_pkg::vreg_addr_t        host_word;
  logic [`VFU_LANE_W-1:0]     host_lane;
  logic                       host_go;
  logic                       ack_q;

  assign host_word = wb_adr_i[`VFU_WB_AW-1:`VFU_LANE_W];
  assign host_lane = wb_adr_i[`VFU_LANE_W-1:0];

  // No host access while an instruction runs or its last write is pending
  assign host_go = wb_cyc_i && wb_stb_i && !ack_q && !busy_i && !wr_i.en;

  //////////////////////////////////////////////////
  // Storage writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_mem
    if (!rst_ni) begin
      for (int w = 0; w < `VFU_NR_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else begin
      if (wr_i.en) begin
        for (int l = 0; l < `VFU_N_IPU; l++) begin
          for (int j = 0; j < LaneB; j++) begin
            if (wr_i.be[l*LaneB+j]) begin
              mem_q[wr_i.addr][l][j] <= wr_i.data[(l*LaneB+j)*8 +: 8];
            end
          end
        end
      end
      // Host write, sel picks the bytes of one lane
      if (host_go && wb_we_i) begin
        for (int j = 0; j < LaneB; j++) begin
          if (wb_sel_i[j]) begin
            mem_q[host_word][host_lane][j] <= wb_dat_i[j*8 +: 8];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rvalid
    if (!rst_ni) begin
      rvalid_o <= '0;
      ack_q    <= 1'b0;
    end else begin
      for (int p = 0; p < 3; p++) begin
        rvalid_o[p] <= rd_i[p].en;
      end
      ack_q <= host_go;
    end
  end

  always_ff @(posedge clk_i) begin : proc_rdata
    for (int p = 0; p < 3; p++) begin
      if (rd_i[p].en) begin
        rdata_o[p] <= mem_q[rd_i[p].addr];
      end
    end
    if (host_go && !wb_we_i) begin
      wb_dat_o <= mem_q[host_word][host_lane];
    end
  end

  assign wb_ack_o = ack_q;

  // Host ack never lands in a cycle where an instruction runs
  a_ack_when_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> !busy_i
  ) else $error("host ack while busy");

endmodule

/* rtl/vfu_writeback.sv */
// Writeback stage
// Registers one group of lane results and writes it to vd, with byte
// enables cut off at the remaining vector length
`include "vfu_settings.svh"

module vfu_writeback (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     grp_valid_i,
  input  vfu_pkg::vreg_addr_t      wr_addr_i,
  input  vfu_pkg::vl_t             vl_left_i,
  input  vfu_pkg::vfu_sew_e        sew_i,
  input  logic [`VFU_WORD_W-1:0]   result_i,
  output vfu_pkg::vrf_wr_t         wr_o
);

  logic [`VFU_VL_W+1:0]     bytes_left;
  logic [`VFU_WORD_B-1:0]   be_d;
  logic [`VFU_WORD_B-1:0]   be_q;
  logic [`VFU_WORD_W-1:0]   data_q;
  vfu_pkg::vreg_addr_t      addr_q;
  logic                     en_q;

  // Remaining elements times bytes per element
  assign bytes_left = {2'b00, vl_left_i} << sew_i;

  always_comb begin : proc_be
    for (int b = 0; b < `VFU_WORD_B; b++) begin
      be_d[b] = (b < int'(bytes_left));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_en
    if (!rst_ni) begin
      en_q <= 1'b0;
    end else begin
      en_q <= grp_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin : proc_payload
    if (grp_valid_i) begin
      addr_q <= wr_addr_i;
      data_q <= result_i;
      be_q   <= be_d;
    end
  end

  assign wr_o.addr = addr_q;
  assign wr_o.data = data_q;
  assign wr_o.be   = be_q;
  assign wr_o.en   = en_q;

  // Each group handed over by the sequencer still has elements left
  a_be_not_empty : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wr_o.en |-> (wr_o.be != '0)
  ) else $error("VRF write with empty byte enable");

endmodule

/* test/tb_vfu.sv */
// Testbench for the vector functional unit
// Loads the register file over Wishbone, runs instructions against a
// shadow model of the registers and reads every result back
`include "vfu_settings.svh"

module tb_vfu;

  localparam int max_wait  = 200;
  localparam int reg_words = `VFU_VLEN / `VFU_ELEN;

  logic                   clk_i;
  logic                   rst_ni;
  vfu_pkg::vfu_req_t      req;
  logic                   req_valid;
  logic                   req_ready;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [`VFU_WB_AW-1:0]  wb_adr;
  logic [31:0]            wb_dat_w;
  logic [3:0]             wb_sel;
  logic [31:0]            wb_dat_r;
  logic                   wb_ack;

  // Check strobe, sampled by the assertions below
  logic                   chk_en;
  logic [31:0]            chk_exp;
  logic [31:0]            chk_act;
  string                  chk_name;

  logic [31:0]            shadow [`VFU_NR_VREG][reg_words];
  int                     seed;

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  vfu_top vfu_top_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_dat_w),
    .wb_sel_i    (wb_sel),
    .wb_dat_o    (wb_dat_r),
    .wb_ack_o    (wb_ack)
  );

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_value : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    chk_en |-> (chk_act == chk_exp)
  ) else begin
    $display("Fail %s: expected %h actual %h", chk_name, chk_exp, chk_act);
    $display("Result: FAILED");
    $fatal(1, "value check failed");
  end

  // Host must stall while an instruction runs
  a_no_ack_busy : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !req_ready |-> !wb_ack
  ) else begin
    $display("Fail host_stall: expected ack 0 actual 1");
    $display("Result: FAILED");
    $fatal(1, "host ack while busy");
  end

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out while waiting for %s", what);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on a timeout");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    chk_name = name;
    chk_exp  = exp;
    chk_act  = act;
    chk_en   = 1'b1;
    step();
    chk_en   = 1'b0;
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      step();
      n++;
      if (n > max_wait) begin
        timeout_fail("host ack");
      end
    end while (!wb_ack);
  endtask

  task automatic host_access(input logic we, input logic [`VFU_WB_AW-1:0] adr,
                             input logic [31:0] dat, output logic [31:0] rdat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_sel   = 4'hf;
    wait_ack();
    rdat     = wb_dat_r;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
  endtask

  task automatic check_reg(input logic [4:0] v, input string name);
    logic [31:0] rdat;
    for (int k = 0; k < reg_words; k++) begin
      host_access(1'b0, {v, 3'(k)}, 32'd0, rdat);
      check_value($sformatf("%s_w%0d", name, k), shadow[v][k], rdat);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic longint to_signed(input logic [31:0] x, input int w);
    longint v;
    v = longint'(x) & ((longint'(1) << w) - 1);
    if (x[w-1]) begin
      v = v - (longint'(1) << w);
    end
    return v;
  endfunction

  // vs2 op vs1, result truncated by the caller
  function automatic logic [31:0] elem_ref(input vfu_pkg::vfu_op_e op, input int w,
      input logic [31:0] x1, input logic [31:0] x2, input logic [31:0] xd);
    longint a;
    longint b;
    longint c;
    longint r;
    a = to_signed(x1, w);
    b = to_signed(x2, w);
    c = to_signed(xd, w);
    case (op)
      vfu_pkg::OP_ADD: r = b + a;
      vfu_pkg::OP_SUB: r = b - a;
      vfu_pkg::OP_AND: r = b & a;
      vfu_pkg::OP_OR:  r = b | a;
      vfu_pkg::OP_XOR: r = b ^ a;
      vfu_pkg::OP_MIN: r = (a < b) ? a : b;
      vfu_pkg::OP_MAX: r = (a > b) ? a : b;
      default:         r = c + a * b;
    endcase
    return 32'(r);
  endfunction

  function automatic logic [31:0] broadcast(input vfu_pkg::vfu_sew_e sew,
                                            input logic [31:0] x);
    case (sew)
      vfu_pkg::SEW_8:  return {4{x[7:0]}};
      vfu_pkg::SEW_16: return {2{x[15:0]}};
      default:         return x;
    endcase
  endfunction

  // Elements at or past vl keep the old vd content
  function automatic logic [31:0] lane_ref(input vfu_pkg::vfu_op_e op,
      input vfu_pkg::vfu_sew_e sew, input logic [31:0] s1, input logic [31:0] s2,
      input logic [31:0] d, input int first, input int vl);
    vfu_pkg::lane_word_u u1;
    vfu_pkg::lane_word_u u2;
    vfu_pkg::lane_word_u ud;
    vfu_pkg::lane_word_u ur;
    u1.w = s1;
    u2.w = s2;
    ud.w = d;
    ur.w = d;
    for (int i = 0; i < 4; i++) begin
      if (sew == vfu_pkg::SEW_8 && first + i < vl) begin
        ur.b[i] = 8'(elem_ref(op, 8, 32'(u1.b[i]), 32'(u2.b[i]), 32'(ud.b[i])));
      end
    end
    for (int i = 0; i < 2; i++) begin
      if (sew == vfu_pkg::SEW_16 && first + i < vl) begin
        ur.h[i] = 16'(elem_ref(op, 16, 32'(u1.h[i]), 32'(u2.h[i]), 32'(ud.h[i])));
      end
    end
    if (sew == vfu_pkg::SEW_32 && first < vl) begin
      ur.w = elem_ref(op, 32, u1.w, u2.w, ud.w);
    end
    return ur.w;
  endfunction

  task automatic update_model(input vfu_pkg::vfu_req_t r);
    logic [31:0] res [reg_words];
    logic [31:0] s1;
    for (int k = 0; k < reg_words; k++) begin
      s1 = r.use_scalar ? broadcast(r.sew, r.rs1) : shadow[r.vs1][k];
      res[k] = lane_ref(r.op, r.sew, s1, shadow[r.vs2][k], shadow[r.vd][k],
                        k * (4 >> int'(r.sew)), int'(r.vl));
    end
    for (int k = 0; k < reg_words; k++) begin
      shadow[r.vd][k] = res[k];
    end
  endtask

  // 16, 8 or 4 elements per group
  function automatic int group_count(input vfu_pkg::vfu_sew_e sew, input int vl);
    int epg;
    epg = 16 >> int'(sew);
    return (vl + epg - 1) / epg;
  endfunction

  //////////////////////////////////////////////////
  // Instruction issue
  //////////////////////////////////////////////////

  task automatic run_instr(input vfu_pkg::vfu_req_t r, input bit probe);
    int n;
    logic [31:0] rdat;
    req       = r;
    req_valid = 1'b1;
    n = 0;
    while (!req_ready) begin
      step();
      n++;
      if (n > max_wait) begin
        timeout_fail("request ready");
      end
    end
    step();
    req_valid = 1'b0;
    // Host read of vd issued while the unit is busy
    if (probe) begin
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = {r.vd, 3'd0};
      wb_sel = 4'hf;
    end
    n = 0;
    while (!req_ready) begin
      step();
      n++;
      if (n > max_wait) begin
        timeout_fail("end of instruction");
      end
    end
    update_model(r);
    check_value("ready_low_cycles", 32'(2 * group_count(r.sew, int'(r.vl))), 32'(n));
    if (probe) begin
      wait_ack();
      rdat   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      check_value("stalled_read", shadow[r.vd][0], rdat);
    end
  endtask

  initial begin : main
    vfu_pkg::vfu_req_t r;
    logic [31:0] rdat;
    int tail_vl [5];
    int tail_sew [5];
    seed      = 32'hd7b7;
    tail_vl   = '{5, 13, 3, 0, 21};
    tail_sew  = '{0, 1, 2, 0, 0};
    rst_ni    = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    wb_sel    = '0;
    chk_en    = 1'b0;
    chk_exp   = '0;
    chk_act   = '0;
    chk_name  = "";
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    step();

    check_value("ready_after_reset", 32'd1, 32'(req_ready));
    for (int v = 0; v < `VFU_NR_VREG; v++) begin
      host_access(1'b0, 8'(v * 8 + v % 8), 32'd0, rdat);
      check_value($sformatf("reset_v%0d", v), 32'd0, rdat);
    end

    // Random register contents
    for (int v = 0; v < `VFU_NR_VREG; v++) begin
      for (int k = 0; k < reg_words; k++) begin
        shadow[v][k] = $random(seed);
        host_access(1'b1, 8'(v * 8 + k), shadow[v][k], rdat);
      end
    end

    // Every operation at every width, full vl
    for (int s = 0; s < 3; s++) begin
      for (int o = 0; o < 8; o++) begin
        r     = '0;
        r.op  = vfu_pkg::vfu_op_e'(o);
        r.sew = vfu_pkg::vfu_sew_e'(s);
        r.vl  = vfu_pkg::vl_t'(32 >> s);
        r.vs2 = 5'(1 + o);
        r.vs1 = 5'(9 + s);
        r.vd  = 5'(16 + o);
        run_instr(r, o == 0);
        check_reg(r.vd, $sformatf("op%0d_sew%0d", o, s));
      end
    end

    // Scalar source 1
    for (int o = 0; o < 8; o++) begin
      r            = '0;
      r.op         = vfu_pkg::vfu_op_e'(o);
      r.sew        = vfu_pkg::vfu_sew_e'(o % 3);
      r.vl         = vfu_pkg::vl_t'(32 >> (o % 3));
      r.vs2        = 5'(24 + o % 4);
      r.vd         = 5'(28 + o % 4);
      r.use_scalar = 1'b1;
      r.rs1        = $random(seed);
      run_instr(r, 1'b0);
      check_reg(r.vd, $sformatf("scalar_op%0d", o));
    end

    // Partial groups and zero length
    for (int i = 0; i < 5; i++) begin
      r     = '0;
      r.op  = (i % 2 == 1) ? vfu_pkg::OP_MACC : vfu_pkg::OP_XOR;
      r.sew = vfu_pkg::vfu_sew_e'(tail_sew[i]);
      r.vl  = vfu_pkg::vl_t'(tail_vl[i]);
      r.vs2 = 5'(2 + i);
      r.vs1 = 5'(10 + i);
      r.vd  = 5'(20 + i);
      run_instr(r, 1'b0);
      check_reg(r.vd, $sformatf("tail_vl%0d", tail_vl[i]));
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule
